// File: compile.f
+incdir+bench
hdl/cpu_pkg.sv
hdl/cpu_bus_if.sv
hdl/microcode_rom.sv
hdl/sequencer.sv
hdl/alu.sv
hdl/register_bank.sv
hdl/program_memory.sv
hdl/cpu_top.sv
bench/cpu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module cpu_tb -f compile.f -o cpu_sim \
    && ./obj_dir/cpu_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1

// File: bench/cpu_cases.svh
`ifndef CPU_CASES_SVH
`define CPU_CASES_SVH

// One test program with its expected final state
typedef struct packed {
    logic [0:15][DATA_WIDTH-1:0] prog;   // Byte 0 is loaded at address 0
    logic [ADDR_WIDTH-1:0]       len;
    logic [DATA_WIDTH-1:0]       exp_a;
    logic [DATA_WIDTH-1:0]       exp_b;
    logic [DATA_WIDTH-1:0]       exp_c;
    logic                        exp_z;
    logic                        exp_cy;
    logic [ADDR_WIDTH-1:0]       exp_pc;
    logic                        exp_halted;
    logic                        exp_illegal;
} case_t;

localparam int NUM_CASES = 13;

// Columns after the program are len, A, B, C, Z, C flag, pc, halted, illegal
localparam case_t CASE_TABLE [NUM_CASES] = '{
    // LDI and MOV where LDI of zero sets Z
    '{{LDI_A, 8'h11, LDI_B, 8'h22, LDI_C, 8'h00, MOV_AC, MOV_BA, HLT, {7{8'h00}}},
      8'd9, 8'h22, 8'h22, 8'h11, 1'b1, 1'b0, 8'h09, 1'b1, 1'b0},
    '{{LDI_A, 8'h44, LDI_B, 8'h55, LDI_C, 8'h66, MOV_CA, MOV_BC, HLT, {7{8'h00}}},
      8'd9, 8'h66, 8'h55, 8'h55, 1'b0, 1'b0, 8'h09, 1'b1, 1'b0},
    '{{LDI_A, 8'h77, LDI_C, 8'h00, MOV_AB, HLT, {10{8'h00}}},
      8'd6, 8'h77, 8'h77, 8'h00, 1'b1, 1'b0, 8'h06, 1'b1, 1'b0},
    // Arithmetic with carry and borrow
    '{{LDI_A, 8'hf0, LDI_C, 8'h20, MOV_CB, ADD_B, HLT, {9{8'h00}}},
      8'd7, 8'h10, 8'h20, 8'h20, 1'b0, 1'b1, 8'h07, 1'b1, 1'b0},
    '{{LDI_A, 8'h30, LDI_B, 8'h31, LDI_C, 8'h30, SUB_C, SUB_B, HLT, {7{8'h00}}},
      8'd9, 8'hcf, 8'h31, 8'h30, 1'b0, 1'b1, 8'h09, 1'b1, 1'b0},
    '{{LDI_A, 8'hfe, INR_A, LDI_B, 8'h00, DCR_B, LDI_C, 8'h01, DCR_C, INR_B, HLT,
       {5{8'h00}}},
      8'd11, 8'hff, 8'h00, 8'h00, 1'b1, 1'b1, 8'h0b, 1'b1, 1'b0},
    // Logic ops clear carry
    '{{LDI_A, 8'h81, LDI_B, 8'h80, ADD_B, LDI_C, 8'h0e, ANA_C, ORA_B, XRA_B, HLT,
       {5{8'h00}}},
      8'd11, 8'h00, 8'h80, 8'h0e, 1'b1, 1'b0, 8'h0b, 1'b1, 1'b0},
    '{{LDI_A, 8'h00, DCR_A, ANI, 8'h3c, ORI, 8'hc0, XRI, 8'hfc, HLT, {6{8'h00}}},
      8'd10, 8'h00, 8'h00, 8'h00, 1'b1, 1'b0, 8'h0a, 1'b1, 1'b0},
    // CMP touches flags only
    '{{LDI_A, 8'h40, LDI_B, 8'h41, LDI_C, 8'h40, CMP_C, CMP_B, HLT, {7{8'h00}}},
      8'd9, 8'h40, 8'h41, 8'h40, 1'b0, 1'b1, 8'h09, 1'b1, 1'b0},
    // Countdown loop
    '{{LDI_B, 8'h05, LDI_A, 8'h00, INR_A, DCR_B, JNZ, 8'h04, HLT, {7{8'h00}}},
      8'd9, 8'h05, 8'h00, 8'h00, 1'b1, 1'b0, 8'h09, 1'b1, 1'b0},
    // Wrong jumps land on LDI_C ee
    '{{LDI_A, 8'hff, JZ, 8'h0d, INR_A, JNZ, 8'h0d, JC, 8'h0b,
       LDI_B, 8'hee, JMP, 8'h0f, LDI_C, 8'hee, HLT},
      8'd16, 8'h00, 8'h00, 8'h00, 1'b1, 1'b1, 8'h10, 1'b1, 1'b0},
    // JC falls through on clear carry, JZ taken, then DCR borrow takes JC
    '{{LDI_A, 8'h00, JC, 8'h0d, JZ, 8'h08, LDI_B, 8'hee,
       DCR_A, JC, 8'h0d, LDI_C, 8'hee, HLT, {2{8'h00}}},
      8'd14, 8'hff, 8'h00, 8'h00, 1'b0, 1'b1, 8'h0e, 1'b1, 1'b0},
    // Unknown opcode at address 2
    '{{LDI_A, 8'h12, 8'hff, LDI_A, 8'h34, LDI_B, 8'h56, HLT, {8{8'h00}}},
      8'd8, 8'h12, 8'h00, 8'h00, 1'b0, 1'b0, 8'h03, 1'b1, 1'b1}
};

`endif

// File: bench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    `include "cpu_cases.svh"

    localparam int HALT_TIMEOUT = 1000;   // Cycles

    logic                  clk;
    logic                  reset;
    logic                  load_en;
    logic [ADDR_WIDTH-1:0] load_addr;
    logic [DATA_WIDTH-1:0] load_data;
    logic [DATA_WIDTH-1:0] reg_a;
    logic [DATA_WIDTH-1:0] reg_b;
    logic [DATA_WIDTH-1:0] reg_c;
    logic                  flag_z;
    logic                  flag_c;
    logic [ADDR_WIDTH-1:0] pc;
    logic                  halted;
    logic                  illegal;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    case_t       idle;
    case_t       rnd_case;

    cpu_top #(
        .MEM_DEPTH (256)
    ) cpu_top_inst (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .reg_a     (reg_a),
        .reg_b     (reg_b),
        .reg_c     (reg_c),
        .flag_z    (flag_z),
        .flag_c    (flag_c),
        .pc        (pc),
        .halted    (halted),
        .illegal   (illegal)
    );

    always #4 clk = ~clk;

    // ================================================
    // Random operands
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    task automatic random_byte(output logic [7:0] value);
        int i;
        value = 8'h00;
        for (i = 0; i < 8; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    // INR_B, DCR_C, SUB_C, ADD_B on random operands
    task automatic build_random_case(output case_t tc);
        logic [7:0] x;
        logic [7:0] y;
        logic [7:0] z;
        logic [7:0] b;
        logic [7:0] c;
        logic [7:0] diff;
        int         sum;
        random_byte(x);
        random_byte(y);
        random_byte(z);
        b    = y + 8'd1;
        c    = z - 8'd1;
        diff = x - c;
        sum  = int'(diff) + int'(b);   // Carry shows above bit 7
        tc.prog        = {LDI_A, x, LDI_B, y, LDI_C, z, INR_B, DCR_C, SUB_C, ADD_B, HLT,
                          {5{8'h00}}};
        tc.len         = 8'd11;
        tc.exp_a       = sum[7:0];
        tc.exp_b       = b;
        tc.exp_c       = c;
        tc.exp_z       = (sum[7:0] == 8'h00);
        tc.exp_cy      = (sum > 255);
        tc.exp_pc      = 8'd11;
        tc.exp_halted  = 1'b1;
        tc.exp_illegal = 1'b0;
    endtask

    // ================================================
    // Checks
    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_outputs(input string tag, input case_t tc);
        check_value({tag, " reg_a"}, reg_a, tc.exp_a);
        check_value({tag, " reg_b"}, reg_b, tc.exp_b);
        check_value({tag, " reg_c"}, reg_c, tc.exp_c);
        check_value({tag, " flag_z"}, {7'h00, flag_z}, {7'h00, tc.exp_z});
        check_value({tag, " flag_c"}, {7'h00, flag_c}, {7'h00, tc.exp_cy});
        check_value({tag, " pc"}, pc, tc.exp_pc);
        check_value({tag, " halted"}, {7'h00, halted}, {7'h00, tc.exp_halted});
        check_value({tag, " illegal"}, {7'h00, illegal}, {7'h00, tc.exp_illegal});
    endtask

    task automatic wait_for_halt(output bit done);
        int cycles;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < HALT_TIMEOUT) begin
            @(negedge clk);
            done = halted;
            cycles++;
        end
    endtask

    // Load during reset, release, run to halt
    task automatic run_case(input case_t tc, input int num);
        logic [7:0] addr;
        bit         done;
        string      tag;
        tag = $sformatf("case %0d", num);
        @(posedge clk);
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        for (addr = 8'd0; addr < tc.len; addr = addr + 8'd1) begin
            load_en   <= 1'b1;
            load_addr <= addr;
            load_data <= tc.prog[addr[3:0]];
            @(posedge clk);
        end
        load_en <= 1'b0;
        @(posedge clk);
        reset <= 1'b0;
        wait_for_halt(done);
        if (done) begin
            check_outputs(tag, tc);
        end else begin
            errors++;
            $display("%s: program did not halt within %0d cycles", tag, HALT_TIMEOUT);
        end
    endtask

    // ================================================
    // Main sequence
    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        lfsr      = 32'h86f8_e4be;
        errors    = 0;
        checks    = 0;
        idle      = '0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_outputs("after reset", idle);   // Nothing loaded yet

        for (int idx = 0; idx < NUM_CASES; idx++) begin
            run_case(CASE_TABLE[idx[3:0]], idx);
        end

        build_random_case(rnd_case);
        run_case(rnd_case, NUM_CASES);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           load_en,
    input  logic [cpu_pkg::ADDR_WIDTH-1:0] load_addr,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] load_data,
    output logic [cpu_pkg::DATA_WIDTH-1:0] reg_a,
    output logic [cpu_pkg::DATA_WIDTH-1:0] reg_b,
    output logic [cpu_pkg::DATA_WIDTH-1:0] reg_c,
    output logic                           flag_z,
    output logic                           flag_c,
    output logic [cpu_pkg::ADDR_WIDTH-1:0] pc,
    output logic                           halted,
    output logic                           illegal
);
    import cpu_pkg::*;

    control_word_t          rom_word;
    logic [MSTEP_WIDTH-1:0] mstep;
    logic [DATA_WIDTH-1:0]  data_bus;
    logic [DATA_WIDTH-1:0]  temp_val;
    logic [DATA_WIDTH-1:0]  alu_result;
    logic                   alu_z;
    logic                   alu_c;
    mem_byte_u              mem_byte;

    cpu_bus_if bus ();

    // ================================================
    // Control
    sequencer sequencer_inst (
        .clk      (clk),
        .reset    (reset),
        .bus      (bus),
        .rom_word (rom_word),
        .mstep    (mstep),
        .halted   (halted),
        .illegal  (illegal)
    );

    microcode_rom microcode_rom_inst (
        .clk      (clk),
        .opcode   (bus.opcode),
        .mstep    (mstep),
        .rom_word (rom_word)
    );

    // ================================================
    // Datapath
    alu alu_inst (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .a_val      (reg_a),
        .b_val      (reg_b),
        .c_val      (reg_c),
        .temp_val   (temp_val),
        .alu_result (alu_result),
        .alu_z      (alu_z),
        .alu_c      (alu_c)
    );

    register_bank register_bank_inst (
        .clk        (clk),
        .reset      (reset),
        .bus        (bus),
        .mem_byte   (mem_byte),
        .alu_result (alu_result),
        .alu_z      (alu_z),
        .alu_c      (alu_c),
        .data_bus   (data_bus),
        .a_val      (reg_a),
        .b_val      (reg_b),
        .c_val      (reg_c),
        .temp_val   (temp_val)
    );

    program_memory #(
        .MEM_DEPTH (MEM_DEPTH)
    ) program_memory_inst (
        .clk       (clk),
        .reset     (reset),
        .bus       (bus),
        .data_bus  (data_bus),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .mem_byte  (mem_byte),
        .pc        (pc)
    );

    assign flag_z = bus.flag_z;
    assign flag_c = bus.flag_c;

endmodule

// File: hdl/program_memory.sv
`timescale 1ns/1ps

module program_memory #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                           clk,
    input  logic                           reset,
    cpu_bus_if.datapath                    bus,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] data_bus,
    input  logic                           load_en,
    input  logic [cpu_pkg::ADDR_WIDTH-1:0] load_addr,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] load_data,
    output cpu_pkg::mem_byte_u             mem_byte,
    output logic [cpu_pkg::ADDR_WIDTH-1:0] pc
);
    import cpu_pkg::*;

    localparam int MEM_AW = $clog2(MEM_DEPTH);

    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
    logic [MEM_AW-1:0]     mar;   // Low PC bits, wraps modulo depth

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (bus.cw.load_pc) begin
            pc <= data_bus;   // Jump target
        end else if (bus.cw.pc_enable) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.cw.load_mar_pc) begin
            mar <= pc[MEM_AW-1:0];
        end
        if (load_en) begin
            mem[load_addr[MEM_AW-1:0]] <= load_data;
        end
        mem_byte.data <= mem[mar];   // Valid the cycle after the read state
    end

    // Programs are loaded only while the core is held in reset
    a_load_in_reset: assert property (@(posedge clk) load_en |-> reset);

endmodule

// File: hdl/register_bank.sv
`timescale 1ns/1ps

module register_bank (
    input  logic                           clk,
    input  logic                           reset,
    cpu_bus_if.datapath                    bus,
    input  cpu_pkg::mem_byte_u             mem_byte,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] alu_result,
    input  logic                           alu_z,
    input  logic                           alu_c,
    output logic [cpu_pkg::DATA_WIDTH-1:0] data_bus,
    output logic [cpu_pkg::DATA_WIDTH-1:0] a_val,
    output logic [cpu_pkg::DATA_WIDTH-1:0] b_val,
    output logic [cpu_pkg::DATA_WIDTH-1:0] c_val,
    output logic [cpu_pkg::DATA_WIDTH-1:0] temp_val
);
    import cpu_pkg::*;

    opcode_t ir;
    logic    flag_z;
    logic    flag_c;

    // ================================================
    // Internal bus, one source at a time
    assign data_bus = ({DATA_WIDTH{bus.cw.oe_a}}    & a_val)
                    | ({DATA_WIDTH{bus.cw.oe_b}}    & b_val)
                    | ({DATA_WIDTH{bus.cw.oe_c}}    & c_val)
                    | ({DATA_WIDTH{bus.cw.oe_temp}} & temp_val)
                    | ({DATA_WIDTH{bus.cw.oe_alu}}  & alu_result)
                    | ({DATA_WIDTH{bus.cw.oe_mem}}  & mem_byte.data);

    always_ff @(posedge clk) begin
        if (reset) begin
            a_val  <= '0;
            b_val  <= '0;
            c_val  <= '0;
            ir     <= NOP;
            flag_z <= 1'b0;
            flag_c <= 1'b0;
        end else begin
            if (bus.cw.load_a) begin
                a_val <= data_bus;
            end
            if (bus.cw.load_b) begin
                b_val <= data_bus;
            end
            if (bus.cw.load_c) begin
                c_val <= data_bus;
            end
            if (bus.cw.load_ir) begin
                ir <= mem_byte.opcode;   // Opcode view of the fetched byte
            end
            if (bus.cw.load_flags && bus.cw.load_sets_z) begin
                flag_z <= (data_bus == '0);   // Immediate loads
            end else if (bus.cw.load_flags) begin
                flag_z <= alu_z;
                flag_c <= alu_c;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.cw.load_temp) begin
            temp_val <= mem_byte.data;   // Operand byte
        end
    end

    assign bus.opcode = ir;
    assign bus.flag_z = flag_z;
    assign bus.flag_c = flag_c;

    // The sequencer never enables two bus sources together
    a_bus_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({bus.cw.oe_a, bus.cw.oe_b, bus.cw.oe_c,
                  bus.cw.oe_temp, bus.cw.oe_alu, bus.cw.oe_mem}));

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic                           clk,
    input  logic                           reset,
    cpu_bus_if.datapath                    bus,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] a_val,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] b_val,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] c_val,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] temp_val,
    output logic [cpu_pkg::DATA_WIDTH-1:0] alu_result,
    output logic                           alu_z,
    output logic                           alu_c
);
    import cpu_pkg::*;

    logic [DATA_WIDTH-1:0] src1;
    logic [DATA_WIDTH-1:0] src2;
    logic [DATA_WIDTH:0]   wide;   // Top bit is carry or borrow

    always_comb begin
        src1 = bus.cw.alu_src1_b ? b_val : (bus.cw.alu_src1_c ? c_val : a_val);
        src2 = bus.cw.alu_src2_temp ? temp_val : (bus.cw.alu_src2_c ? c_val : b_val);
        case (bus.cw.alu_op)
            ALU_ADD: wide = {1'b0, src1} + {1'b0, src2};
            ALU_SUB: wide = {1'b0, src1} - {1'b0, src2};
            ALU_AND: wide = {1'b0, src1 & src2};
            ALU_OR:  wide = {1'b0, src1 | src2};
            ALU_XOR: wide = {1'b0, src1 ^ src2};
            ALU_INR: wide = {1'b0, src1} + (DATA_WIDTH + 1)'(1);
            ALU_DCR: wide = {1'b0, src1} - (DATA_WIDTH + 1)'(1);
            default: wide = '0;
        endcase
    end

    // Latched in step 0, read back in step 1
    always_ff @(posedge clk) begin
        if (reset) begin
            alu_result <= '0;
            alu_c      <= 1'b0;
        end else if (bus.cw.alu_op != ALU_NONE) begin
            alu_result <= wide[DATA_WIDTH-1:0];
            alu_c      <= wide[DATA_WIDTH];
        end
    end

    assign alu_z = (alu_result == '0);

endmodule

// File: hdl/sequencer.sv
`timescale 1ns/1ps

module sequencer (
    input  logic                            clk,
    input  logic                            reset,
    cpu_bus_if.ctrl                         bus,
    input  cpu_pkg::control_word_t          rom_word,
    output logic [cpu_pkg::MSTEP_WIDTH-1:0] mstep,
    output logic                            halted,
    output logic                            illegal
);
    import cpu_pkg::*;

    fsm_state_t             state;
    fsm_state_t             next_state;
    logic [MSTEP_WIDTH-1:0] next_mstep;
    logic [1:0]             byte_count;
    logic [1:0]             next_byte_count;
    logic [1:0]             n_operands;
    logic                   known_opcode;
    logic                   next_illegal;
    logic                   check_jump;
    logic                   jump_taken;
    control_word_t          cw;

    // ================================================
    // Operand bytes per opcode
    always_comb begin
        known_opcode = 1'b1;
        n_operands   = 2'd0;
        case (bus.opcode)
            LDI_A, LDI_B, LDI_C, ANI, ORI, XRI, JMP, JZ, JNZ, JC:
                n_operands = 2'd1;
            NOP, HLT, MOV_AB, MOV_AC, MOV_BA, MOV_BC, MOV_CA, MOV_CB,
            ADD_B, ADD_C, SUB_B, SUB_C, CMP_B, CMP_C, ANA_B, ANA_C,
            ORA_B, ORA_C, XRA_B, XRA_C, INR_A, DCR_A, INR_B, DCR_B, INR_C, DCR_C:
                n_operands = 2'd0;
            default: known_opcode = 1'b0;
        endcase
    end

    assign check_jump = rom_word.check_zero | rom_word.check_not_zero | rom_word.check_carry;
    assign jump_taken = (rom_word.check_zero & bus.flag_z)
                      | (rom_word.check_not_zero & ~bus.flag_z)
                      | (rom_word.check_carry & bus.flag_c);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_RESET;
            mstep      <= '0;
            byte_count <= '0;
            illegal    <= 1'b0;
        end else begin
            state      <= next_state;
            mstep      <= next_mstep;
            byte_count <= next_byte_count;
            illegal    <= next_illegal;
        end
    end

    // ================================================
    // Fetch and execute
    always_comb begin
        next_state      = state;
        next_mstep      = mstep;
        next_byte_count = byte_count;
        next_illegal    = illegal;
        cw              = '0;
        case (state)
            S_RESET:      next_state = S_LATCH_ADDR;
            S_LATCH_ADDR: begin
                cw.load_mar_pc = 1'b1;
                next_state     = S_READ_BYTE;
            end
            S_READ_BYTE:  next_state = S_LATCH_BYTE;   // Memory output register fills
            S_LATCH_BYTE: begin
                cw.oe_mem       = 1'b1;
                cw.pc_enable    = 1'b1;
                next_byte_count = byte_count + 2'd1;
                next_state      = S_CHK_MORE_BYTES;
                case (byte_count)
                    2'd0:    cw.load_ir = 1'b1;
                    2'd1:    cw.load_temp = 1'b1;
                    default: begin
                        next_illegal = 1'b1;   // Byte count overflow
                        next_state   = S_HALT;
                    end
                endcase
            end
            S_CHK_MORE_BYTES: begin
                if (!known_opcode) begin
                    next_illegal = 1'b1;
                    next_state   = S_HALT;
                end else if (byte_count > n_operands) begin
                    next_byte_count = '0;
                    next_state      = S_EXECUTE;
                end else begin
                    next_state = S_LATCH_ADDR;
                end
            end
            S_EXECUTE: begin
                cw         = rom_word;
                next_mstep = '0;
                if (rom_word.halt) begin
                    next_state = S_HALT;
                end else if (check_jump && !jump_taken) begin
                    cw.load_pc = 1'b0;   // Fall through to the next opcode
                    next_state = S_LATCH_ADDR;
                end else if (rom_word.last_step) begin
                    next_state = S_LATCH_ADDR;
                end else begin
                    next_mstep = mstep + 1'b1;
                end
            end
            default: next_state = S_HALT;   // Held until reset
        endcase
    end

    assign bus.cw = cw;
    assign halted = (state == S_HALT);

    // Every microcode sequence ends before the step counter wraps
    a_mstep_bound: assert property (@(posedge clk) disable iff (reset)
        (state == S_EXECUTE && mstep == MSTEP_WIDTH'(MICROSTEPS - 1))
            |-> (rom_word.last_step || rom_word.halt));

    a_halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted);

endmodule

// File: hdl/microcode_rom.sv
`timescale 1ns/1ps

module microcode_rom (
    input  logic                            clk,
    input  cpu_pkg::opcode_t                opcode,
    input  logic [cpu_pkg::MSTEP_WIDTH-1:0] mstep,
    output cpu_pkg::control_word_t          rom_word
);
    import cpu_pkg::*;

    // ALU opcode entry, step 0 latches and step 1 writes back
    typedef struct packed {
        alu_op_t    op;
        logic       src1_b;
        logic       src1_c;
        logic       src2_c;
        logic       src2_temp;
        logic [2:0] dest;   // One-hot {C, B, A}
    } alu_entry_t;

    alu_entry_t ent;

    always_comb begin
        case (opcode)                                   // op  s1b s1c s2c s2t  dest
            ADD_B:   ent = '{ALU_ADD, 1'b0, 1'b0, 1'b0, 1'b0, 3'b001};
            ADD_C:   ent = '{ALU_ADD, 1'b0, 1'b0, 1'b1, 1'b0, 3'b001};
            SUB_B:   ent = '{ALU_SUB, 1'b0, 1'b0, 1'b0, 1'b0, 3'b001};
            SUB_C:   ent = '{ALU_SUB, 1'b0, 1'b0, 1'b1, 1'b0, 3'b001};
            CMP_B:   ent = '{ALU_SUB, 1'b0, 1'b0, 1'b0, 1'b0, 3'b000};
            CMP_C:   ent = '{ALU_SUB, 1'b0, 1'b0, 1'b1, 1'b0, 3'b000};
            ANA_B:   ent = '{ALU_AND, 1'b0, 1'b0, 1'b0, 1'b0, 3'b001};
            ANA_C:   ent = '{ALU_AND, 1'b0, 1'b0, 1'b1, 1'b0, 3'b001};
            ORA_B:   ent = '{ALU_OR,  1'b0, 1'b0, 1'b0, 1'b0, 3'b001};
            ORA_C:   ent = '{ALU_OR,  1'b0, 1'b0, 1'b1, 1'b0, 3'b001};
            XRA_B:   ent = '{ALU_XOR, 1'b0, 1'b0, 1'b0, 1'b0, 3'b001};
            XRA_C:   ent = '{ALU_XOR, 1'b0, 1'b0, 1'b1, 1'b0, 3'b001};
            ANI:     ent = '{ALU_AND, 1'b0, 1'b0, 1'b0, 1'b1, 3'b001};
            ORI:     ent = '{ALU_OR,  1'b0, 1'b0, 1'b0, 1'b1, 3'b001};
            XRI:     ent = '{ALU_XOR, 1'b0, 1'b0, 1'b0, 1'b1, 3'b001};
            INR_A:   ent = '{ALU_INR, 1'b0, 1'b0, 1'b0, 1'b0, 3'b001};
            DCR_A:   ent = '{ALU_DCR, 1'b0, 1'b0, 1'b0, 1'b0, 3'b001};
            INR_B:   ent = '{ALU_INR, 1'b1, 1'b0, 1'b0, 1'b0, 3'b010};
            DCR_B:   ent = '{ALU_DCR, 1'b1, 1'b0, 1'b0, 1'b0, 3'b010};
            INR_C:   ent = '{ALU_INR, 1'b0, 1'b1, 1'b0, 1'b0, 3'b100};
            DCR_C:   ent = '{ALU_DCR, 1'b0, 1'b1, 1'b0, 1'b0, 3'b100};
            default: ent = '0;
        endcase
    end

    always_comb begin
        rom_word = '0;
        if (ent.op != ALU_NONE) begin
            if (mstep == 2'd0) begin
                rom_word.alu_op        = ent.op;
                rom_word.alu_src1_b    = ent.src1_b;
                rom_word.alu_src1_c    = ent.src1_c;
                rom_word.alu_src2_c    = ent.src2_c;
                rom_word.alu_src2_temp = ent.src2_temp;
            end else if (mstep == 2'd1) begin
                rom_word.oe_alu     = |ent.dest;   // CMP keeps A untouched
                rom_word.load_a     = ent.dest[0];
                rom_word.load_b     = ent.dest[1];
                rom_word.load_c     = ent.dest[2];
                rom_word.load_flags = 1'b1;
                rom_word.last_step  = 1'b1;
            end
        end else if (mstep == 2'd0) begin
            rom_word.last_step = 1'b1;   // Everything else is one step
            case (opcode)
                HLT: begin
                    rom_word.last_step = 1'b0;
                    rom_word.halt      = 1'b1;
                end
                LDI_A, LDI_B, LDI_C: begin
                    rom_word.oe_temp     = 1'b1;
                    rom_word.load_a      = (opcode == LDI_A);
                    rom_word.load_b      = (opcode == LDI_B);
                    rom_word.load_c      = (opcode == LDI_C);
                    rom_word.load_flags  = 1'b1;
                    rom_word.load_sets_z = 1'b1;
                end
                MOV_AB, MOV_AC, MOV_BA, MOV_BC, MOV_CA, MOV_CB: begin
                    rom_word.oe_a   = opcode inside {MOV_AB, MOV_AC};
                    rom_word.oe_b   = opcode inside {MOV_BA, MOV_BC};
                    rom_word.oe_c   = opcode inside {MOV_CA, MOV_CB};
                    rom_word.load_a = opcode inside {MOV_BA, MOV_CA};
                    rom_word.load_b = opcode inside {MOV_AB, MOV_CB};
                    rom_word.load_c = opcode inside {MOV_AC, MOV_BC};
                end
                JMP, JZ, JNZ, JC: begin
                    rom_word.oe_temp        = 1'b1;   // Target byte onto the bus
                    rom_word.load_pc        = 1'b1;
                    rom_word.check_zero     = (opcode == JZ);
                    rom_word.check_not_zero = (opcode == JNZ);
                    rom_word.check_carry    = (opcode == JC);
                end
                default: rom_word.last_step = (opcode == NOP);   // Unknown stays empty
            endcase
        end
    end

    // A later step is only reached from a step that did not finish
    a_step_order: assert property (@(posedge clk)
        (mstep != '0) |-> $past(!rom_word.last_step && !rom_word.halt));

endmodule

// File: hdl/cpu_bus_if.sv
`timescale 1ns/1ps

interface cpu_bus_if;
    import cpu_pkg::*;

    control_word_t cw;       // Acts on the next rising edge
    opcode_t       opcode;   // IR contents
    logic          flag_z;
    logic          flag_c;

    modport ctrl (
        output cw,
        input  opcode, flag_z, flag_c
    );

    modport datapath (
        input  cw,
        output opcode, flag_z, flag_c
    );

endinterface

// File: hdl/cpu_pkg.sv
package cpu_pkg;

    // ================================================
    // Sizes
    localparam int DATA_WIDTH  = 8;
    localparam int ADDR_WIDTH  = 8;   // One-byte jump targets
    localparam int MICROSTEPS  = 4;   // ROM entries per opcode
    localparam int MSTEP_WIDTH = 2;

    // ================================================
    // Instruction set, grouped by high nibble
    typedef enum logic [DATA_WIDTH-1:0] {
        NOP    = 8'h00, HLT    = 8'h01,
        LDI_A  = 8'h10, LDI_B  = 8'h11, LDI_C  = 8'h12,
        MOV_AB = 8'h20, MOV_AC = 8'h21, MOV_BA = 8'h22,
        MOV_BC = 8'h23, MOV_CA = 8'h24, MOV_CB = 8'h25,
        ADD_B  = 8'h30, ADD_C  = 8'h31, SUB_B  = 8'h32,
        SUB_C  = 8'h33, CMP_B  = 8'h34, CMP_C  = 8'h35,
        ANA_B  = 8'h40, ANA_C  = 8'h41, ORA_B  = 8'h42,
        ORA_C  = 8'h43, XRA_B  = 8'h44, XRA_C  = 8'h45,
        ANI    = 8'h48, ORI    = 8'h49, XRI    = 8'h4a,
        INR_A  = 8'h50, DCR_A  = 8'h51, INR_B  = 8'h52,
        DCR_B  = 8'h53, INR_C  = 8'h54, DCR_C  = 8'h55,
        JMP    = 8'h60, JZ     = 8'h61, JNZ    = 8'h62,
        JC     = 8'h63
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_NONE = 3'd0,   // Result register holds
        ALU_ADD  = 3'd1,
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_OR   = 3'd4,
        ALU_XOR  = 3'd5,
        ALU_INR  = 3'd6,
        ALU_DCR  = 3'd7
    } alu_op_t;

    typedef enum logic [2:0] {
        S_RESET, S_LATCH_ADDR, S_READ_BYTE, S_LATCH_BYTE,
        S_CHK_MORE_BYTES, S_EXECUTE, S_HALT
    } fsm_state_t;

    // ================================================
    // Control word
    typedef struct packed {
        logic    oe_a, oe_b, oe_c, oe_temp, oe_alu, oe_mem;   // Bus sources
        logic    load_a, load_b, load_c, load_ir, load_temp;
        logic    load_flags, load_pc, load_mar_pc;
        logic    pc_enable;
        alu_op_t alu_op;
        logic    alu_src2_c, alu_src2_temp;   // Else B
        logic    alu_src1_b, alu_src1_c;      // Else A
        logic    load_sets_z;                 // Z from bus value, C kept
        logic    check_zero, check_not_zero, check_carry;
        logic    last_step, halt;
    } control_word_t;

    // Fetched byte, opcode for IR or operand for TEMP
    typedef union packed {
        opcode_t               opcode;
        logic [DATA_WIDTH-1:0] data;
    } mem_byte_u;

endpackage
